// ==== decodeStage.sv ====
// ID stage with control decode, immediates, branch resolution, hazard detection and ID/EX
`timescale 1ns/1ps

module decodeStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  rvPkg::wordT     ifInst,
	input  rvPkg::wordT     ifPc,
	input  rvPkg::wordT     ifLinkPc,
	input  rvPkg::regWriteT exFwd,
	input  logic            exIsLoad,
	input  rvPkg::regWriteT meFwd,
	input  logic            meIsLoad,
	input  rvPkg::regWriteT wbWrite,
	output logic            hazardStall,
	output logic            redirect,
	output rvPkg::wordT     target,
	output rvPkg::idExT     idEx
);
	import rvPkg::*;

	opcodeE     opcode;
	logic [2:0] funct3;
	regAddrT    rs1;
	regAddrT    rs2;
	wordT       rs1Data;
	wordT       rs2Data;
	wordT       rs1Val;
	wordT       rs2Val;
	wordT       imm;
	wordT       jalrSum;
	ctrlT       ctrl;
	idExT       idExNext;
	logic       isBranch;
	logic       isJal;
	logic       isJalr;
	logic       usesRs1;
	logic       usesRs2;
	logic       taken;
	logic       loadUse;
	logic       branchDep;

	assign opcode   = opcodeE'(ifInst[6:0]);
	assign funct3   = ifInst[14:12];
	assign rs1      = ifInst[19:15];
	assign rs2      = ifInst[24:20];
	assign isBranch = (opcode == opBranch);
	assign isJal    = (opcode == opJal);
	assign isJalr   = (opcode == opJalr);
	assign usesRs1  = opcode inside {opReg, opImm, opLoad, opStore, opBranch, opJalr};
	assign usesRs2  = opcode inside {opReg, opStore, opBranch};

	regFile uRegFile (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (rs1),
		.rs2     (rs2),
		.wr      (wbWrite),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	// ==============================
	// Control and immediates
	// ==============================
	always_comb begin
		ctrl = '0;
		case (opcode)
			opReg: begin
				ctrl.aluOp    = aluOpE'({ifInst[30], funct3});
				ctrl.regWrite = 1'b1;
			end
			opImm: begin
				// funct7 bit only matters for srai
				ctrl.aluOp    = aluOpE'({ifInst[30] & (funct3 == 3'b101), funct3});
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opLoad: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opStore: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opJal, opJalr: begin
				ctrl.regWrite = 1'b1;
				ctrl.isJump   = 1'b1;
			end
			default: ctrl = '0;   // Branches need no later-stage control
		endcase
	end

	always_comb begin
		case (opcode)
			opStore:  imm = {{20{ifInst[31]}}, ifInst[31:25], ifInst[11:7]};
			opBranch: imm = {{20{ifInst[31]}}, ifInst[7], ifInst[30:25], ifInst[11:8], 1'b0};
			opJal:    imm = {{12{ifInst[31]}}, ifInst[19:12], ifInst[20], ifInst[30:21], 1'b0};
			default:  imm = {{20{ifInst[31]}}, ifInst[31:20]};
		endcase
		if (opcode == opImm && funct3[1:0] == 2'b01) begin
			imm = {27'b0, ifInst[24:20]};   // Shift amount only
		end
	end

	// ==============================
	// Branch resolution and hazards
	// ==============================
	// WB values arrive through the register file bypass
	assign rs1Val  = writesReg(meFwd, rs1) ? meFwd.data : rs1Data;
	assign rs2Val  = writesReg(meFwd, rs2) ? meFwd.data : rs2Data;
	assign jalrSum = rs1Val + imm;
	assign taken   = isBranch && ((rs1Val == rs2Val) ^ funct3[0]);   // funct3[0] set for bne
	assign target  = isJalr ? {jalrSum[31:1], 1'b0} : ifPc + imm;

	assign loadUse = exIsLoad && ((usesRs1 && writesReg(exFwd, rs1)) ||
		(usesRs2 && writesReg(exFwd, rs2)));
	// Compare in ID cannot see EX results or load data still in ME
	assign branchDep = ((isBranch || isJalr) &&
		(writesReg(exFwd, rs1) || (meIsLoad && writesReg(meFwd, rs1)))) ||
		(isBranch && (writesReg(exFwd, rs2) || (meIsLoad && writesReg(meFwd, rs2))));

	assign hazardStall = loadUse | branchDep;
	assign redirect    = !hazardStall && (taken || isJal || isJalr);

	always_comb begin
		idExNext.ctrl    = hazardStall ? ctrlT'('0) : ctrl;   // Bubble on hazard
		idExNext.rs1Data = rs1Data;
		idExNext.rs2Data = rs2Data;
		idExNext.imm     = imm;
		idExNext.linkPc  = ifLinkPc;
		idExNext.rs1     = rs1;
		idExNext.rs2     = rs2;
		idExNext.rd      = ifInst[11:7];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idEx.ctrl <= '0;
		end else if (!stall) begin
			idEx <= idExNext;
		end
	end

	// The word fetched behind a taken redirect must never reach decode
	assert property (@(posedge clk) disable iff (!rst_n)
		redirect && !stall |=> ifInst == nopInst)
		else $error("Wrong-path instruction reached decode after redirect");

endmodule

// ==== executeStage.sv ====
// EX stage with operand forwarding, the ALU and the EX/MEM register, instantiated by riscvCore
`timescale 1ns/1ps

module executeStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  rvPkg::idExT     idEx,
	input  rvPkg::regWriteT meFwd,
	input  rvPkg::regWriteT wbWrite,
	output rvPkg::regWriteT exFwd,
	output logic            exIsLoad,
	output rvPkg::exMemT    exMem
);
	import rvPkg::*;

	wordT opA;
	wordT rs2Fwd;
	wordT opB;
	wordT aluResult;

	assign opA    = fwdPick(idEx.rs1, idEx.rs1Data, meFwd, wbWrite);
	assign rs2Fwd = fwdPick(idEx.rs2, idEx.rs2Data, meFwd, wbWrite);
	assign opB    = idEx.ctrl.aluSrc ? idEx.imm : rs2Fwd;

	// ==============================
	// ALU
	// ==============================
	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd:  aluResult = opA + opB;
			aluSub:  aluResult = opA - opB;
			aluSll:  aluResult = opA << opB[4:0];
			aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
			aluXor:  aluResult = opA ^ opB;
			aluSrl:  aluResult = opA >> opB[4:0];
			aluSra:  aluResult = wordT'($signed(opA) >>> opB[4:0]);
			aluOr:   aluResult = opA | opB;
			aluAnd:  aluResult = opA & opB;
			default: aluResult = '0;
		endcase
	end

	// Seen by decode for load-use and branch checks
	assign exFwd.en   = idEx.ctrl.regWrite;
	assign exFwd.rd   = idEx.rd;
	assign exFwd.data = aluResult;
	assign exIsLoad   = idEx.ctrl.memRead;

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMem.memRead  <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.isJump   <= 1'b0;
		end else if (!stall) begin
			exMem.memRead   <= idEx.ctrl.memRead;
			exMem.memWrite  <= idEx.ctrl.memWrite;
			exMem.memToReg  <= idEx.ctrl.memToReg;
			exMem.regWrite  <= idEx.ctrl.regWrite;
			exMem.isJump    <= idEx.ctrl.isJump;
			exMem.aluResult <= aluResult;
			exMem.storeData <= rs2Fwd;   // Store data after forwarding
			exMem.linkPc    <= idEx.linkPc;
			exMem.rd        <= idEx.rd;
		end
	end

endmodule

// ==== fetchStage.sv ====
// IF stage with PC register, next-PC choice and the IF/ID register, instantiated by riscvCore
`timescale 1ns/1ps

module fetchStage (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           stall,
	input  logic           hazardStall,
	input  logic           redirect,
	input  rvPkg::wordT    target,
	input  rvPkg::wordT    iData,
	output rvPkg::memAddrT iAddr,
	output rvPkg::wordT    ifInst,
	output rvPkg::wordT    ifPc,
	output rvPkg::wordT    ifLinkPc
);
	import rvPkg::*;

	wordT pc;
	wordT pcPlus4;
	wordT nextPc;
	logic hold;

	assign hold    = stall | hazardStall;
	assign pcPlus4 = pc + 32'd4;
	assign iAddr   = pc[31:2];

	// Static not-taken, fall through unless decode redirects
	always_comb begin
		if (hold) begin
			nextPc = pc;
		end else if (redirect) begin
			nextPc = target;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= resetPc;
		end else begin
			pc <= nextPc;
		end
	end

	// ==============================
	// IF/ID register
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ifInst <= nopInst;
		end else if (!hold) begin
			ifInst <= redirect ? nopInst : iData;   // Squash the wrong-path word
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			ifPc     <= pc;
			ifLinkPc <= pcPlus4;
		end
	end

	// Targets from decode must keep fetch on word boundaries
	assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("PC not word aligned: %h", pc);

endmodule

// ==== memWbStage.sv ====
// MEM and WB stages with data port request, MEM/WB register and write-back select
`timescale 1ns/1ps

module memWbStage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  rvPkg::exMemT    exMem,
	input  rvPkg::wordT     dRdata,
	output rvPkg::dataReqT  dReq,
	output rvPkg::regWriteT meFwd,
	output logic            meIsLoad,
	output rvPkg::regWriteT wbWrite
);
	import rvPkg::*;

	memWbT memWb;

	assign dReq.read  = exMem.memRead;
	assign dReq.write = exMem.memWrite;
	assign dReq.addr  = exMem.aluResult[31:2];
	assign dReq.wdata = exMem.storeData;

	// Load data is not ready here, decode stalls on meIsLoad
	assign meFwd.en   = exMem.regWrite;
	assign meFwd.rd   = exMem.rd;
	assign meFwd.data = exMem.isJump ? exMem.linkPc : exMem.aluResult;
	assign meIsLoad   = exMem.memRead;

	// ==============================
	// MEM/WB register
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memWb.memToReg <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.isJump   <= 1'b0;
		end else if (!stall) begin
			memWb.memToReg  <= exMem.memToReg;
			memWb.regWrite  <= exMem.regWrite;
			memWb.isJump    <= exMem.isJump;
			memWb.aluResult <= exMem.aluResult;
			memWb.loadData  <= dRdata;
			memWb.linkPc    <= exMem.linkPc;
			memWb.rd        <= exMem.rd;
		end
	end

	assign wbWrite.en   = memWb.regWrite & ~stall;   // Frozen with the rest of the pipe
	assign wbWrite.rd   = memWb.rd;
	assign wbWrite.data = memWb.isJump ? memWb.linkPc :
		memWb.memToReg ? memWb.loadData : memWb.aluResult;

	// Decode never sets both, so this guards the whole control path
	assert property (@(posedge clk) disable iff (!rst_n) !(dReq.read && dReq.write))
		else $error("Data port read and write together");

endmodule

// ==== regFile.sv ====
// Integer register file with x0 tied low and same-cycle write bypass, used by decodeStage
`timescale 1ns/1ps

module regFile (
	input  logic            clk,
	input  logic            rst_n,
	input  rvPkg::regAddrT  rs1,
	input  rvPkg::regAddrT  rs2,
	input  rvPkg::regWriteT wr,
	output rvPkg::wordT     rs1Data,
	output rvPkg::wordT     rs2Data
);
	import rvPkg::*;

	wordT regs [1:31];   // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en && wr.rd != '0) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// Write-through so WB and ID can share a cycle
	always_comb begin
		if (writesReg(wr, rs1)) begin
			rs1Data = wr.data;
		end else begin
			rs1Data = (rs1 == '0) ? '0 : regs[rs1];
		end
		if (writesReg(wr, rs2)) begin
			rs2Data = wr.data;
		end else begin
			rs2Data = (rs2 == '0) ? '0 : regs[rs2];
		end
	end

endmodule

// ==== riscvCore.sv ====
// Top of the five-stage RV32 core, connects the stages to the instruction and data ports
`timescale 1ns/1ps

module riscvCore (
	input  logic           clk,
	input  logic           rst_n,
	output rvPkg::memAddrT iAddr,
	input  rvPkg::wordT    iData,
	input  logic           iStall,
	output rvPkg::dataReqT dReq,
	input  rvPkg::wordT    dRdata,
	input  logic           dStall
);
	import rvPkg::*;

	logic     stall;       // Global freeze from either port
	logic     hazardStall;
	logic     redirect;
	logic     exIsLoad;
	logic     meIsLoad;
	wordT     target;
	wordT     ifInst;
	wordT     ifPc;
	wordT     ifLinkPc;
	idExT     idEx;
	exMemT    exMem;
	regWriteT exFwd;
	regWriteT meFwd;
	regWriteT wbWrite;

	assign stall = iStall | dStall;

	fetchStage uFetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.hazardStall (hazardStall),
		.redirect    (redirect),
		.target      (target),
		.iData       (iData),
		.iAddr       (iAddr),
		.ifInst      (ifInst),
		.ifPc        (ifPc),
		.ifLinkPc    (ifLinkPc)
	);

	decodeStage uDecode (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.ifInst      (ifInst),
		.ifPc        (ifPc),
		.ifLinkPc    (ifLinkPc),
		.exFwd       (exFwd),
		.exIsLoad    (exIsLoad),
		.meFwd       (meFwd),
		.meIsLoad    (meIsLoad),
		.wbWrite     (wbWrite),
		.hazardStall (hazardStall),
		.redirect    (redirect),
		.target      (target),
		.idEx        (idEx)
	);

	executeStage uExecute (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.idEx     (idEx),
		.meFwd    (meFwd),
		.wbWrite  (wbWrite),
		.exFwd    (exFwd),
		.exIsLoad (exIsLoad),
		.exMem    (exMem)
	);

	memWbStage uMemWb (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.exMem    (exMem),
		.dRdata   (dRdata),
		.dReq     (dReq),
		.meFwd    (meFwd),
		.meIsLoad (meIsLoad),
		.wbWrite  (wbWrite)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the core and its testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tbRiscvCore -f sources.f -o simRiscvCore
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simRiscvCore > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0

// ==== rvPkg.sv ====
// Types, encodings and constants shared by all pipeline stages; imported inside each module
package rvPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;
	typedef logic [29:0] memAddrT;   // Word address

	typedef enum logic [6:0] {
		opReg    = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111
	} opcodeE;

	// Bit 3 selects sub and sra, low bits follow funct3
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSll = 4'b0001,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluSrl = 4'b0101,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111,
		aluSub = 4'b1000,
		aluSra = 4'b1101
	} aluOpE;

	typedef struct packed {
		aluOpE aluOp;
		logic  aluSrc;     // Immediate as operand B
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  regWrite;
		logic  isJump;     // Write back link PC
	} ctrlT;

	typedef struct packed {
		ctrlT    ctrl;
		wordT    rs1Data;
		wordT    rs2Data;
		wordT    imm;
		wordT    linkPc;
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
	} idExT;

	typedef struct packed {
		logic    memRead;
		logic    memWrite;
		logic    memToReg;
		logic    regWrite;
		logic    isJump;
		wordT    aluResult;
		wordT    storeData;
		wordT    linkPc;
		regAddrT rd;
	} exMemT;

	typedef struct packed {
		logic    memToReg;
		logic    regWrite;
		logic    isJump;
		wordT    aluResult;
		wordT    loadData;
		wordT    linkPc;
		regAddrT rd;
	} memWbT;

	// One register write, also used as a forward source
	typedef struct packed {
		logic    en;
		regAddrT rd;
		wordT    data;
	} regWriteT;

	typedef struct packed {
		logic    read;
		logic    write;
		memAddrT addr;
		wordT    wdata;
	} dataReqT;

	localparam wordT nopInst = 32'h0000_0013;   // addi x0, x0, 0
	localparam wordT resetPc = 32'h0000_0000;

	// True when w writes register r, x0 never counts
	function automatic logic writesReg(regWriteT w, regAddrT r);
		return w.en && (w.rd != '0) && (w.rd == r);
	endfunction

	// Newest value wins, ME before WB before the register file
	function automatic wordT fwdPick(regAddrT r, wordT rfVal, regWriteT me, regWriteT wb);
		if (writesReg(me, r)) begin
			return me.data;
		end
		if (writesReg(wb, r)) begin
			return wb.data;
		end
		return rfVal;
	endfunction

endpackage

// ==== sources.f ====
+incdir+.
rvPkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
riscvCore.sv
tbRiscvCore.sv

// ==== tbRefModel.svh ====
// Testbench helpers included by tbRiscvCore: encoders, program builder and ISA reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ==============================
// Instruction encoders
// ==============================
function automatic logic [31:0] rType(int alt, int f3, int rd, int rs1, int rs2);
	return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] iFormat(logic [6:0] op, int f3, int rd, int rs1, int imm);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] immOp(int f3, int rd, int rs1, int imm);
	return iFormat(7'b0010011, f3, rd, rs1, imm);
endfunction

function automatic logic [31:0] loadWord(int rd, int rs1, int imm);
	return iFormat(7'b0000011, 2, rd, rs1, imm);
endfunction

function automatic logic [31:0] jumpReg(int rd, int rs1, int imm);
	return iFormat(7'b1100111, 0, rd, rs1, imm);
endfunction

function automatic logic [31:0] sType(int rs1, int rs2, int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// f3 is 0 for beq, 1 for bne
function automatic logic [31:0] bType(int f3, int rs1, int rs2, int imm);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jType(int rd, int imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic emit(logic [31:0] w);
	imem[progLen[7:0]] = w;
	progLen++;
endtask

// Initial data memory contents, shared by the memory model and the reference
function automatic logic [31:0] fillWord(int i);
	return (32'(i) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
endfunction

// ==============================
// Program builder
// ==============================
task automatic buildProgram();
	int f3;
	int alt;
	int rd;
	int rs1;
	int rs2;
	int imm;
	int useImm;
	for (int i = 0; i < 256; i++) begin
		imem[i[7:0]] = 32'h0000_0013;   // nop fill
	end
	progLen = 0;
	// Dependent chains, forwarded from ME and WB
	emit(immOp(0, 1, 0, -300));
	emit(immOp(0, 2, 1, 77));
	emit(rType(1, 0, 3, 2, 1));        // sub
	emit(rType(0, 1, 4, 1, 3));        // sll by register
	emit(immOp(5, 5, 1, 'h403));       // srai
	emit(immOp(5, 6, 4, 7));           // srli
	emit(rType(0, 2, 7, 1, 2));
	emit(immOp(2, 8, 2, -1000));       // slti
	emit(rType(0, 4, 9, 5, 6));
	emit(rType(1, 5, 10, 9, 3));       // sra
	emit(rType(0, 6, 11, 10, 7));
	emit(immOp(7, 12, 11, 1365));
	emit(immOp(4, 13, 12, -1));
	emit(immOp(0, 0, 1, 5));           // Write to x0
	emit(rType(0, 0, 14, 0, 13));
	// Loads and stores
	emit(immOp(0, 20, 0, 'h100));
	emit(sType(20, 13, 0));
	emit(loadWord(15, 20, 0));
	emit(rType(0, 0, 16, 15, 15));     // Load-use
	emit(sType(20, 16, 4));            // Store of forwarded data
	emit(loadWord(17, 20, 8));         // Preset word
	// Branches and jumps
	emit(bType(0, 17, 17, 8));         // Taken on just-loaded operand
	emit(immOp(0, 18, 0, 1));
	emit(bType(1, 17, 15, 8));
	emit(immOp(0, 18, 18, 2));
	emit(immOp(0, 19, 18, 3));
	emit(bType(0, 19, 18, 8));         // Not taken, just computed
	emit(immOp(0, 21, 0, 9));
	emit(bType(1, 21, 21, 8));         // Not taken
	emit(jType(22, 8));
	emit(immOp(0, 21, 21, 100));       // Skipped by jal
	emit(jumpReg(23, 22, 12));
	emit(immOp(0, 21, 21, 200));       // Skipped by jalr
	emit(immOp(0, 24, 0, 4));
	emit(bType(1, 24, 0, 8));          // Depends on EX
	emit(immOp(0, 25, 0, 1));
	emit(loadWord(26, 20, 12));
	emit(immOp(0, 27, 0, 3));
	emit(bType(0, 26, 26, 8));         // Load still in ME
	emit(immOp(0, 27, 0, 1));
	// Random arithmetic, no sltu and no subi
	for (int k = 0; k < 40; k++) begin
		f3     = $unsigned($random(seed)) % 8;
		rd     = $unsigned($random(seed)) % 32;
		rs1    = $unsigned($random(seed)) % 32;
		rs2    = $unsigned($random(seed)) % 32;
		imm    = $random(seed) % 2048;
		useImm = $unsigned($random(seed)) % 2;
		alt    = $unsigned($random(seed)) % 2;
		if (f3 == 3) begin
			f3 = 2;
		end
		if (f3 != 0 && f3 != 5) begin
			alt = 0;
		end
		if (useImm == 0) begin
			emit(rType(alt, f3, rd, rs1, rs2));
		end else if (f3 == 1 || f3 == 5) begin
			emit(immOp(f3, rd, rs1, alt * 'h400 + rs2));   // rs2 reused as shamt
		end else begin
			emit(immOp(f3, rd, rs1, imm));
		end
	end
	for (int i = 0; i < 32; i++) begin
		emit(sType(0, i, 'h200 + 4 * i));
	end
	emit(jType(0, 0));                 // Halt loop
endtask

// ==============================
// ISA reference model
// ==============================
function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt,
	logic [31:0] a, logic [31:0] b);
	logic [31:0] r;
	case (f3)
		3'd0: r = alt ? a - b : a + b;
		3'd1: r = a << b[4:0];
		3'd2: r = {31'b0, $signed(a) < $signed(b)};
		3'd4: r = a ^ b;
		3'd5: begin
			if (alt) begin
				r = $signed(a) >>> b[4:0];
			end else begin
				r = a >> b[4:0];
			end
		end
		3'd6: r = a | b;
		default: r = a & b;
	endcase
	return r;
endfunction

// Fills expAddr/expData, returns the number of instructions executed
function automatic int runReference();
	logic [31:0] x [32];
	logic [31:0] mem [1024];
	logic [31:0] pc;
	logic [31:0] nextPc;
	logic [31:0] inst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immJ;
	logic [31:0] addr;
	logic [31:0] res;
	logic        wr;
	int          steps;
	for (int i = 0; i < 32; i++) begin
		x[i[4:0]] = '0;
	end
	for (int i = 0; i < 1024; i++) begin
		mem[i[9:0]] = fillWord(i);
	end
	expAddr.delete();
	expData.delete();
	pc    = '0;
	steps = 0;
	while (steps < 4096) begin
		inst   = imem[pc[9:2]];
		a      = x[inst[19:15]];
		b      = x[inst[24:20]];
		immI   = {{20{inst[31]}}, inst[31:20]};
		immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		immB   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		immJ   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		nextPc = pc + 32'd4;
		res    = '0;
		wr     = 1'b0;
		case (inst[6:0])
			7'b0110011: begin
				res = aluModel(inst[14:12], inst[30], a, b);
				wr  = 1'b1;
			end
			7'b0010011: begin
				if (inst[13:12] == 2'b01) begin   // Shift by immediate
					res = aluModel(inst[14:12], inst[30], a, {27'b0, inst[24:20]});
				end else begin
					res = aluModel(inst[14:12], 1'b0, a, immI);
				end
				wr = 1'b1;
			end
			7'b0000011: begin
				addr = a + immI;
				res  = mem[addr[11:2]];
				wr   = 1'b1;
			end
			7'b0100011: begin
				addr = a + immS;
				mem[addr[11:2]] = b;
				expAddr.push_back(addr[31:2]);
				expData.push_back(b);
			end
			7'b1100011: begin
				if ((a == b) != inst[12]) begin
					nextPc = pc + immB;
				end
			end
			7'b1101111: begin
				res    = pc + 32'd4;
				wr     = 1'b1;
				nextPc = pc + immJ;
			end
			7'b1100111: begin
				res    = pc + 32'd4;
				wr     = 1'b1;
				addr   = a + immI;
				nextPc = {addr[31:1], 1'b0};
			end
			default: ;
		endcase
		if (wr && inst[11:7] != 5'd0) begin
			x[inst[11:7]] = res;
		end
		steps++;
		if (nextPc == pc) begin
			break;   // Reached jal x0,0
		end
		pc = nextPc;
	end
	return steps;
endfunction

`endif

// ==== tbRiscvCore.sv ====
// Testbench top for riscvCore, runs one program with and without port stalls against a model
`timescale 1ns/1ps

module tbRiscvCore;
	import rvPkg::*;

	logic        clk    = 1'b0;
	logic        rst_n  = 1'b0;
	logic        iStall = 1'b0;
	logic        dStall = 1'b0;
	memAddrT     iAddr;
	wordT        iData;
	dataReqT     dReq;
	wordT        dRdata;

	logic [31:0] imem [256];
	logic [31:0] dmem [1024];
	logic [29:0] expAddr [$];   // Word addresses
	logic [31:0] expData [$];
	integer      seed = 32'he576ab5a;
	int          progLen;
	int          storeIdx;
	int          mismatches;
	int          extraStores;
	int          resetErrors;
	int          refSteps;
	int          watchLimit;   // ns, 0 until sized

	`include "tbRefModel.svh"

	always #20 clk = ~clk;

	riscvCore uut (
		.clk    (clk),
		.rst_n  (rst_n),
		.iAddr  (iAddr),
		.iData  (iData),
		.iStall (iStall),
		.dReq   (dReq),
		.dRdata (dRdata),
		.dStall (dStall)
	);

	// Combinational reads on both ports, data only on a read strobe
	assign iData  = imem[iAddr[7:0]];
	assign dRdata = dReq.read ? dmem[dReq.addr[9:0]] : '0;

	// ==============================
	// Store compare
	// ==============================
	always @(posedge clk) begin
		if (!rst_n) begin
			storeIdx <= 0;
			for (int i = 0; i < 1024; i++) begin
				dmem[i[9:0]] <= fillWord(i);
			end
		end else if (dReq.write && !iStall && !dStall) begin   // Store leaves MEM here
			dmem[dReq.addr[9:0]] <= dReq.wdata;
			if (storeIdx >= expAddr.size()) begin
				extraStores++;
				$display("Unexpected store at %0t to word %h after all expected stores",
					$time, dReq.addr);
			end else begin
				if (dReq.addr != expAddr[storeIdx]) begin
					mismatches++;
					$display("ERROR %0t: store %0d went to word %h, expected %h",
						$time, storeIdx, dReq.addr, expAddr[storeIdx]);
				end
				if (dReq.wdata != expData[storeIdx]) begin
					mismatches++;
					$display("ERROR %0t: store %0d wrote %h, expected %h",
						$time, storeIdx, dReq.wdata, expData[storeIdx]);
				end
			end
			storeIdx <= storeIdx + 1;
		end
	end

	// One program run from reset, random stall levels if asked
	task automatic runPass(input int withStalls);
		@(posedge clk);
		rst_n  <= 1'b0;
		iStall <= 1'b0;
		dStall <= 1'b0;
		repeat (15) @(posedge clk);
		@(negedge clk);
		if (iAddr != '0 || dReq.read || dReq.write) begin
			resetErrors++;
			$display("ERROR %0t: in reset iAddr=%h read=%b write=%b",
				$time, iAddr, dReq.read, dReq.write);
		end
		@(posedge clk);
		rst_n <= 1'b1;
		while (storeIdx < expAddr.size()) begin
			@(posedge clk);
			if (withStalls != 0) begin
				iStall <= ($random(seed) & 3) == 0;
				dStall <= ($random(seed) & 3) == 0;
			end
		end
		iStall <= 1'b0;
		dStall <= 1'b0;
		repeat (8) @(posedge clk);   // Catch stray stores after the list
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		buildProgram();
		refSteps   = runReference();
		watchLimit = 2 * (refSteps * 12 + 60) * 40;   // Two passes, worst stall rate
		runPass(0);
		runPass(1);
		$display("Summary: %0d store mismatches, %0d extra stores, %0d reset errors, %0d stores",
			mismatches, extraStores, resetErrors, expAddr.size());
		if (mismatches == 0 && extraStores == 0 && resetErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (watchLimit > 0);
		#(watchLimit);
		$display("Timeout at %0t: %0d of %0d stores missing in the current pass",
			$time, expAddr.size() - storeIdx, expAddr.size());
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
